/* source/regfile_geom_pkg.sv */
// register file geometry
`default_nettype none

package regfile_geom_pkg;

  localparam int data_width = 32;
  localparam int reg_count = 32;
  localparam int addr_width = $clog2(reg_count);

  // low address bit picks the bank, the rest index inside it
  localparam int bank_count = 2;
  localparam int bank_depth = reg_count / bank_count;
  localparam int bank_addr_width = $clog2(bank_depth);

  localparam int read_ports = 2;
  localparam int write_ports = 2;

  typedef logic [data_width-1:0] data_t;
  typedef logic [addr_width-1:0] reg_addr_t;
  typedef logic [bank_addr_width-1:0] bank_addr_t;

endpackage

`default_nettype wire

/* source/regfile_ctrl_pkg.sv */
// register file control encodings
`default_nettype none

package regfile_ctrl_pkg;

  typedef enum logic {
    sweep_clear = 1'b0,
    sweep_done  = 1'b1
  } sweep_state_e;

  // where a read result comes from
  typedef enum logic [1:0] {
    src_none  = 2'd0,
    src_reg   = 2'd1,
    src_const = 2'd2
  } read_src_e;

endpackage

`default_nettype wire

/* source/regfile_ifs.sv */
// register file internal interfaces
`default_nettype none

// one issued read slot, src_none when empty
interface read_req_if;
  regfile_ctrl_pkg::read_src_e src;
  regfile_geom_pkg::reg_addr_t addr;
  regfile_geom_pkg::data_t     const_val;

  modport issue_side (
    output src,
    output addr,
    output const_val
  );

  modport forward_side (
    input src,
    input addr,
    input const_val
  );
endinterface

// write held for one cycle before it reaches a bank
interface write_stage_if;
  logic                        en;
  regfile_geom_pkg::reg_addr_t addr;
  regfile_geom_pkg::data_t     data;

  modport stage_side (
    output en,
    output addr,
    output data
  );

  modport forward_side (
    input en,
    input addr,
    input data
  );
endinterface

`default_nettype wire

/* source/read_issue.sv */
// read request issue stage
`default_nettype none

module read_issue (
  input  wire logic                                                       clk,
  input  wire logic                                                       rst,
  input  wire logic                                                       ready,
  input  wire logic [regfile_geom_pkg::read_ports-1:0]                    rd_en,
  input  wire regfile_geom_pkg::reg_addr_t [regfile_geom_pkg::read_ports-1:0] rd_addr,
  input  wire logic [regfile_geom_pkg::read_ports-1:0]                    rd_const_en,
  input  wire regfile_geom_pkg::data_t [regfile_geom_pkg::read_ports-1:0] rd_const,
  read_req_if.issue_side                                                  req [regfile_geom_pkg::read_ports]
);

  genvar p;

  for (p = 0; p < regfile_geom_pkg::read_ports; p++) begin : g_port

    // reads are only accepted once the clearing sweep is over
    always_ff @(posedge clk) begin
      if (rst) begin
        req[p].src <= regfile_ctrl_pkg::src_none;
      end else if (ready && rd_en[p] && rd_const_en[p]) begin
        req[p].src <= regfile_ctrl_pkg::src_const;
      end else if (ready && rd_en[p]) begin
        req[p].src <= regfile_ctrl_pkg::src_reg;
      end else begin
        req[p].src <= regfile_ctrl_pkg::src_none;
      end
    end

    always_ff @(posedge clk) begin
      req[p].addr      <= rd_addr[p];
      req[p].const_val <= rd_const[p];
    end

  end

endmodule

`default_nettype wire

/* source/regfile_bank.sv */
// register file storage bank
`default_nettype none

module regfile_bank (
  input  wire logic                                                            clk,
  input  wire logic [regfile_geom_pkg::write_ports-1:0]                        we,
  input  wire regfile_geom_pkg::bank_addr_t [regfile_geom_pkg::write_ports-1:0] waddr,
  input  wire regfile_geom_pkg::data_t [regfile_geom_pkg::write_ports-1:0]    wdata,
  input  wire regfile_geom_pkg::bank_addr_t [regfile_geom_pkg::read_ports-1:0] raddr,
  output      regfile_geom_pkg::data_t [regfile_geom_pkg::read_ports-1:0]     rdata
);

  regfile_geom_pkg::data_t mem [regfile_geom_pkg::bank_depth];

  // later ports override earlier ones on the same entry
  always_ff @(posedge clk) begin
    for (int w = 0; w < regfile_geom_pkg::write_ports; w++) begin
      if (we[w]) begin
        mem[waddr[w]] <= wdata[w];
      end
    end
  end

  always_comb begin
    for (int r = 0; r < regfile_geom_pkg::read_ports; r++) begin
      rdata[r] = mem[raddr[r]];
    end
  end

endmodule

`default_nettype wire

/* source/bank_store.sv */
// write staging and banked storage
`default_nettype none

module bank_store (
  input  wire logic                                                           clk,
  input  wire logic                                                           rst,
  input  wire logic [regfile_geom_pkg::write_ports-1:0]                       wr_en,
  input  wire regfile_geom_pkg::reg_addr_t [regfile_geom_pkg::write_ports-1:0] wr_addr,
  input  wire regfile_geom_pkg::data_t [regfile_geom_pkg::write_ports-1:0]   wr_data,
  input  wire regfile_geom_pkg::reg_addr_t [regfile_geom_pkg::read_ports-1:0] raddr,
  output      regfile_geom_pkg::data_t [regfile_geom_pkg::read_ports-1:0]    rdata,
  output      logic                                                           ready,
  write_stage_if.stage_side                                                   stage [regfile_geom_pkg::write_ports]
);

  localparam int aw = regfile_geom_pkg::addr_width;

  regfile_ctrl_pkg::sweep_state_e sweep_state;
  regfile_geom_pkg::bank_addr_t   sweep_idx;
  logic                           sweeping;

  logic [regfile_geom_pkg::write_ports-1:0]                        stg_en;
  regfile_geom_pkg::reg_addr_t [regfile_geom_pkg::write_ports-1:0] stg_addr;
  regfile_geom_pkg::data_t [regfile_geom_pkg::write_ports-1:0]     stg_data;

  logic [regfile_geom_pkg::write_ports-1:0]                         bank_we [regfile_geom_pkg::bank_count];
  regfile_geom_pkg::bank_addr_t [regfile_geom_pkg::write_ports-1:0] bank_waddr [regfile_geom_pkg::bank_count];
  regfile_geom_pkg::data_t [regfile_geom_pkg::write_ports-1:0]      bank_wdata [regfile_geom_pkg::bank_count];
  regfile_geom_pkg::bank_addr_t [regfile_geom_pkg::read_ports-1:0]  bank_raddr;
  regfile_geom_pkg::data_t [regfile_geom_pkg::read_ports-1:0]       bank_rdata [regfile_geom_pkg::bank_count];

  assign sweeping = (sweep_state == regfile_ctrl_pkg::sweep_clear);
  assign ready    = ~sweeping;

  // one entry of every bank is zeroed per cycle after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      sweep_state <= regfile_ctrl_pkg::sweep_clear;
      sweep_idx   <= '0;
    end else if (sweeping) begin
      sweep_idx <= sweep_idx + 1'b1;
      if (sweep_idx == regfile_geom_pkg::bank_addr_t'(regfile_geom_pkg::bank_depth - 1)) begin
        sweep_state <= regfile_ctrl_pkg::sweep_done;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      stg_en <= '0;
    end else begin
      stg_en <= wr_en & {regfile_geom_pkg::write_ports{~sweeping}};
    end
  end

  always_ff @(posedge clk) begin
    stg_addr <= wr_addr;
    stg_data <= wr_data;
  end

  // steer staged writes by the low address bit, the sweep takes port 0 of each bank
  always_comb begin
    for (int b = 0; b < regfile_geom_pkg::bank_count; b++) begin
      for (int w = 0; w < regfile_geom_pkg::write_ports; w++) begin
        if (sweeping) begin
          bank_we[b][w]    = (w == 0);
          bank_waddr[b][w] = sweep_idx;
          bank_wdata[b][w] = '0;
        end else begin
          bank_we[b][w]    = stg_en[w] && (stg_addr[w][0] == b[0]);
          bank_waddr[b][w] = stg_addr[w][aw-1:1];
          bank_wdata[b][w] = stg_data[w];
        end
      end
    end
  end

  always_comb begin
    for (int r = 0; r < regfile_geom_pkg::read_ports; r++) begin
      bank_raddr[r] = raddr[r][aw-1:1];
      rdata[r]      = bank_rdata[raddr[r][0]][r];
    end
  end

  genvar b, w;

  for (w = 0; w < regfile_geom_pkg::write_ports; w++) begin : g_stage
    assign stage[w].en   = stg_en[w];
    assign stage[w].addr = stg_addr[w];
    assign stage[w].data = stg_data[w];
  end

  for (b = 0; b < regfile_geom_pkg::bank_count; b++) begin : g_bank
    regfile_bank bank_inst (
      .clk   (clk),
      .we    (bank_we[b]),
      .waddr (bank_waddr[b]),
      .wdata (bank_wdata[b]),
      .raddr (bank_raddr),
      .rdata (bank_rdata[b])
    );
  end

endmodule

`default_nettype wire

/* source/operand_forward.sv */
// operand select and output register
`default_nettype none

module operand_forward (
  input  wire logic                                                            clk,
  input  wire logic                                                            rst,
  read_req_if.forward_side                                                     req [regfile_geom_pkg::read_ports],
  write_stage_if.forward_side                                                  stage [regfile_geom_pkg::write_ports],
  output      regfile_geom_pkg::reg_addr_t [regfile_geom_pkg::read_ports-1:0] bank_addr,
  input  wire regfile_geom_pkg::data_t [regfile_geom_pkg::read_ports-1:0]     bank_data,
  output      regfile_geom_pkg::data_t [regfile_geom_pkg::read_ports-1:0]     rd_data,
  output      logic [regfile_geom_pkg::read_ports-1:0]                         rd_valid
);

  regfile_ctrl_pkg::read_src_e [regfile_geom_pkg::read_ports-1:0] req_src;
  regfile_geom_pkg::reg_addr_t [regfile_geom_pkg::read_ports-1:0] req_addr;
  regfile_geom_pkg::data_t [regfile_geom_pkg::read_ports-1:0]     req_const;
  logic [regfile_geom_pkg::write_ports-1:0]                        stg_en;
  regfile_geom_pkg::reg_addr_t [regfile_geom_pkg::write_ports-1:0] stg_addr;
  regfile_geom_pkg::data_t [regfile_geom_pkg::write_ports-1:0]     stg_data;
  regfile_geom_pkg::data_t [regfile_geom_pkg::read_ports-1:0]      fwd_data;

  genvar p, w;

  for (p = 0; p < regfile_geom_pkg::read_ports; p++) begin : g_req
    assign req_src[p]   = req[p].src;
    assign req_addr[p]  = req[p].addr;
    assign req_const[p] = req[p].const_val;
  end

  for (w = 0; w < regfile_geom_pkg::write_ports; w++) begin : g_stage
    assign stg_en[w]   = stage[w].en;
    assign stg_addr[w] = stage[w].addr;
    assign stg_data[w] = stage[w].data;
  end

  assign bank_addr = req_addr;

  // a staged write has not reached the bank yet, so it takes priority
  // the higher port is checked last and wins a same-address collision
  always_comb begin
    for (int r = 0; r < regfile_geom_pkg::read_ports; r++) begin
      fwd_data[r] = bank_data[r];
      for (int s = 0; s < regfile_geom_pkg::write_ports; s++) begin
        if (stg_en[s] && (stg_addr[s] == req_addr[r])) begin
          fwd_data[r] = stg_data[s];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid <= '0;
    end else begin
      for (int r = 0; r < regfile_geom_pkg::read_ports; r++) begin
        rd_valid[r] <= (req_src[r] != regfile_ctrl_pkg::src_none);
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int r = 0; r < regfile_geom_pkg::read_ports; r++) begin
      if (req_src[r] == regfile_ctrl_pkg::src_const) begin
        rd_data[r] <= req_const[r];
      end else begin
        rd_data[r] <= fwd_data[r];
      end
    end
  end

endmodule

`default_nettype wire

/* source/regfile_top.sv */
// banked register file top level
`default_nettype none

module regfile_top (
  input  wire logic                                                            clk,
  input  wire logic                                                            rst,
  output      logic                                                            ready,
  input  wire logic [regfile_geom_pkg::read_ports-1:0]                         rd_en,
  input  wire regfile_geom_pkg::reg_addr_t [regfile_geom_pkg::read_ports-1:0] rd_addr,
  input  wire logic [regfile_geom_pkg::read_ports-1:0]                         rd_const_en,
  input  wire regfile_geom_pkg::data_t [regfile_geom_pkg::read_ports-1:0]     rd_const,
  output      regfile_geom_pkg::data_t [regfile_geom_pkg::read_ports-1:0]     rd_data,
  output      logic [regfile_geom_pkg::read_ports-1:0]                         rd_valid,
  input  wire logic [regfile_geom_pkg::write_ports-1:0]                        wr_en,
  input  wire regfile_geom_pkg::reg_addr_t [regfile_geom_pkg::write_ports-1:0] wr_addr,
  input  wire regfile_geom_pkg::data_t [regfile_geom_pkg::write_ports-1:0]    wr_data
);

  regfile_geom_pkg::reg_addr_t [regfile_geom_pkg::read_ports-1:0] bank_addr;
  regfile_geom_pkg::data_t [regfile_geom_pkg::read_ports-1:0]     bank_data;

  read_req_if    req_if [regfile_geom_pkg::read_ports] ();
  write_stage_if stage_if [regfile_geom_pkg::write_ports] ();

  read_issue read_issue_inst (
    .clk         (clk),
    .rst         (rst),
    .ready       (ready),
    .rd_en       (rd_en),
    .rd_addr     (rd_addr),
    .rd_const_en (rd_const_en),
    .rd_const    (rd_const),
    .req         (req_if)
  );

  bank_store bank_store_inst (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .raddr   (bank_addr),
    .rdata   (bank_data),
    .ready   (ready),
    .stage   (stage_if)
  );

  operand_forward operand_forward_inst (
    .clk       (clk),
    .rst       (rst),
    .req       (req_if),
    .stage     (stage_if),
    .bank_addr (bank_addr),
    .bank_data (bank_data),
    .rd_data   (rd_data),
    .rd_valid  (rd_valid)
  );

endmodule

`default_nettype wire

/* testbench/regfile_assertions.sv */
// register file protocol assertions
`default_nettype none

module regfile_assertions (
  input wire logic                                     clk,
  input wire logic                                     rst,
  input wire logic                                     ready,
  input wire logic [regfile_geom_pkg::read_ports-1:0] rd_valid
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  // a result needs a read accepted with ready high two edges before
  valid_needs_ready: assert property (
    @(posedge clk) disable iff (rst) !$past(ready) |-> (rd_valid == '0)
  ) else begin
    $error("rd_valid high although ready was low on the previous edge");
    fail_count++;
  end

  no_read_in_reset: assert property (
    @(posedge clk) rst |=> ##1 (rd_valid == '0)
  ) else begin
    $error("read accepted while rst was high");
    fail_count++;
  end

  ready_stays_high: assert property (
    @(posedge clk) disable iff (rst) ($past(ready) && !$past(rst)) |-> ready
  ) else begin
    $error("ready fell without a reset");
    fail_count++;
  end

endmodule

bind regfile_top regfile_assertions regfile_assertions_inst (
  .clk      (clk),
  .rst      (rst),
  .ready    (ready),
  .rd_valid (rd_valid)
);

`default_nettype wire

/* testbench/regfile_tb.sv */
// register file testbench
`default_nettype none

module regfile_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int rp = regfile_geom_pkg::read_ports;
  localparam int wp = regfile_geom_pkg::write_ports;
  localparam int ready_timeout = 64;
  localparam int random_rows = 16;

  // one table row is one cycle of stimulus on every port
  typedef struct packed {
    logic [wp-1:0]                        wr_en;
    regfile_geom_pkg::reg_addr_t [wp-1:0] wr_addr;
    regfile_geom_pkg::data_t [wp-1:0]     wr_data;
    logic [rp-1:0]                        rd_en;
    regfile_geom_pkg::reg_addr_t [rp-1:0] rd_addr;
    logic [rp-1:0]                        rd_const_en;
    regfile_geom_pkg::data_t [rp-1:0]     rd_const;
  } row_t;

  typedef struct packed {
    int                               row;
    logic [rp-1:0]                    valid;
    regfile_geom_pkg::data_t [rp-1:0] data;
  } exp_t;

  logic                                 clk;
  logic                                 rst;
  logic                                 ready;
  logic [rp-1:0]                        rd_en;
  regfile_geom_pkg::reg_addr_t [rp-1:0] rd_addr;
  logic [rp-1:0]                        rd_const_en;
  regfile_geom_pkg::data_t [rp-1:0]     rd_const;
  regfile_geom_pkg::data_t [rp-1:0]     rd_data;
  logic [rp-1:0]                        rd_valid;
  logic [wp-1:0]                        wr_en;
  regfile_geom_pkg::reg_addr_t [wp-1:0] wr_addr;
  regfile_geom_pkg::data_t [wp-1:0]     wr_data;

  row_t  rows [$];
  string row_names [$];
  exp_t  exp_q [$];
  regfile_geom_pkg::data_t shadow [regfile_geom_pkg::reg_count] = '{default: '0};
  regfile_geom_pkg::data_t d [6];

  regfile_top regfile_top_inst (
    .clk         (clk),
    .rst         (rst),
    .ready       (ready),
    .rd_en       (rd_en),
    .rd_addr     (rd_addr),
    .rd_const_en (rd_const_en),
    .rd_const    (rd_const),
    .rd_data     (rd_data),
    .rd_valid    (rd_valid),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped after the first error");
  endtask

  task automatic compare_value(
    input string                                     name,
    input logic [regfile_geom_pkg::data_width-1:0] expected,
    input logic [regfile_geom_pkg::data_width-1:0] actual
  );
    if (actual !== expected) begin
      stop_run($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic add_row(
    input string                                name,
    input logic [wp-1:0]                        we,
    input regfile_geom_pkg::reg_addr_t [wp-1:0] wa,
    input regfile_geom_pkg::data_t [wp-1:0]     wd,
    input logic [rp-1:0]                        re,
    input regfile_geom_pkg::reg_addr_t [rp-1:0] ra,
    input logic [rp-1:0]                        ce,
    input regfile_geom_pkg::data_t [rp-1:0]     cv
  );
    rows.push_back(row_t'({we, wa, wd, re, ra, ce, cv}));
    row_names.push_back(name);
  endtask

  task automatic build_table();
    int i;
    for (i = 0; i < 6; i++) begin
      d[i] = $urandom;
    end
    add_row("zero_read", 2'b00, '0, '0, 2'b11, {5'd16, 5'd15}, 2'b00, '0);
    add_row("zero_read_high", 2'b00, '0, '0, 2'b11, {5'd30, 5'd31}, 2'b00, '0);
    add_row("write_both_banks", 2'b11, {5'd10, 5'd5}, {d[1], d[0]}, 2'b00, '0, 2'b00, '0);
    add_row("idle_gap", 2'b00, '0, '0, 2'b00, '0, 2'b00, '0);
    add_row("read_back", 2'b00, '0, '0, 2'b11, {5'd10, 5'd5}, 2'b00, '0);
    add_row("read_swapped", 2'b00, '0, '0, 2'b11, {5'd5, 5'd10}, 2'b00, '0);
    add_row("same_cycle", 2'b01, {5'd0, 5'd7}, {32'd0, d[2]}, 2'b11, {5'd7, 5'd7}, 2'b00, '0);
    add_row("next_cycle", 2'b00, '0, '0, 2'b11, {5'd7, 5'd7}, 2'b00, '0);
    add_row("collide", 2'b11, {5'd12, 5'd12}, {d[4], d[3]}, 2'b11, {5'd12, 5'd12}, 2'b00, '0);
    add_row("collide_fwd", 2'b00, '0, '0, 2'b11, {5'd12, 5'd12}, 2'b00, '0);
    add_row("collide_bank", 2'b00, '0, '0, 2'b11, {5'd12, 5'd12}, 2'b00, '0);
    add_row("const_read", 2'b00, '0, '0, 2'b11, {5'd5, 5'd5}, 2'b01, {32'd0, d[5]});
    add_row("const_both", 2'b00, '0, '0, 2'b11, {5'd12, 5'd10}, 2'b11, {d[1], d[3]});
    // back-to-back traffic on every read port
    for (i = 0; i < random_rows; i++) begin
      add_row($sformatf("stream_%0d", i), 2'($urandom), {5'($urandom), 5'($urandom)},
              {$urandom, $urandom}, 2'b11, {5'($urandom), 5'($urandom)},
              {($urandom_range(3) == 0), ($urandom_range(3) == 0)}, {$urandom, $urandom});
    end
  endtask

  task automatic drive_inputs(input row_t r);
    wr_en       = r.wr_en;
    wr_addr     = r.wr_addr;
    wr_data     = r.wr_data;
    rd_en       = r.rd_en;
    rd_addr     = r.rd_addr;
    rd_const_en = r.rd_const_en;
    rd_const    = r.rd_const;
  endtask

  task automatic wait_for_ready();
    int   cycles;
    row_t r;
    cycles = 0;
    // requests during the sweep must be ignored and writes dropped
    while (ready !== 1'b1) begin
      r         = '0;
      r.wr_en   = '1;
      r.wr_addr = {5'(cycles + 1), 5'(cycles)};
      r.wr_data = '1;
      r.rd_en   = '1;
      r.rd_addr = r.wr_addr;
      drive_inputs(r);
      @(negedge clk);
      compare_value("sweep_read rd_valid", '0, rd_valid);
      cycles++;
      if (cycles > ready_timeout) begin
        stop_run("timed out waiting for ready to rise after reset");
      end
    end
    compare_value("sweep_length", regfile_geom_pkg::bank_depth, cycles);
    // the read sampled on the last sweep edge returns nothing either
    drive_inputs('0);
    @(negedge clk);
    compare_value("sweep_last rd_valid", '0, rd_valid);
  endtask

  task automatic apply_row(input int idx);
    row_t r;
    exp_t e;
    int   w;
    int   p;
    r = rows[idx];
    drive_inputs(r);
    // write-first, port 1 applied last so it wins a collision
    for (w = 0; w < wp; w++) begin
      if (r.wr_en[w]) begin
        shadow[r.wr_addr[w]] = r.wr_data[w];
      end
    end
    e.row   = idx;
    e.valid = r.rd_en;
    for (p = 0; p < rp; p++) begin
      e.data[p] = r.rd_const_en[p] ? r.rd_const[p] : shadow[r.rd_addr[p]];
    end
    exp_q.push_back(e);
  endtask

  task automatic check_result(input exp_t e);
    int p;
    for (p = 0; p < rp; p++) begin
      compare_value($sformatf("%s rd_valid[%0d]", row_names[e.row], p), e.valid[p], rd_valid[p]);
      if (e.valid[p]) begin
        compare_value($sformatf("%s rd_data[%0d]", row_names[e.row], p), e.data[p], rd_data[p]);
      end
    end
  endtask

  initial begin
    int i;
    void'($urandom(32'h4db66719));
    rst = 1'b1;
    drive_inputs('0);
    build_table();
    repeat (5) @(posedge clk);
    @(negedge clk);
    compare_value("reset ready", '0, ready);
    compare_value("reset rd_valid", '0, rd_valid);
    rst = 1'b0;
    wait_for_ready();
    // each result is checked two edges after its request
    for (i = 0; i < rows.size() + 2; i++) begin
      if (i >= 2) begin
        check_result(exp_q.pop_front());
      end
      if (i < rows.size()) begin
        apply_row(i);
      end else begin
        drive_inputs('0);
      end
      @(negedge clk);
    end
    if (regfile_top_inst.regfile_assertions_inst.fail_count != 0) begin
      stop_run($sformatf("FAIL assertions expected 0 actual %0d",
                         regfile_top_inst.regfile_assertions_inst.fail_count));
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* list.f */
source/regfile_geom_pkg.sv
source/regfile_ctrl_pkg.sv
source/regfile_ifs.sv
source/read_issue.sv
source/regfile_bank.sv
source/bank_store.sv
source/operand_forward.sv
source/regfile_top.sv
testbench/regfile_assertions.sv
testbench/regfile_tb.sv

/* Bender.yml */
package:
  name: regfile

sources:
  - files:
      - source/regfile_geom_pkg.sv
      - source/regfile_ctrl_pkg.sv
      - source/regfile_ifs.sv
      - source/read_issue.sv
      - source/regfile_bank.sv
      - source/bank_store.sv
      - source/operand_forward.sv
      - source/regfile_top.sv
  - target: test
    files:
      - testbench/regfile_assertions.sv
      - testbench/regfile_tb.sv
